/* test/hidden_backward_testdata.hex */
// line 1: op reps d[0..3] q_forward[0..3] x[0..2], line 2: expected dh[0..3]
// line 3: expected weight_grad[0..11] row-major; op 1 sample, 2 clear, 3 start+clear while busy
// q = 0, near +1, near -1 and 0.5 with negative d
0001 0001 0200 ff00 0180 fe80 0000 0f5c f0a4 0800 1000 0800 f800
0200 ffeb 001e fee0
000200 000100 ffff00 ffffeb fffff5 00000a 00001e 00000f fffff1 fffee0 ffff70 000090
// second sample of the batch, q = +1 and -1 give zero gradient
0001 0001 0100 0100 ff00 0080 0000 1000 0400 f000 2000 f000 0c00
0100 0000 ff10 0000
000400 000000 ffffc0 ffffeb fffff5 00000a fffe3e 0000ff ffff3d fffee0 ffff70 000090
// clear between batches
0002 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000
000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000
// fresh batch, truncation toward minus infinity
0001 0001 0333 fccd 0010 7fff 0200 fe00 0b50 0000 0100 ffff 4000
0326 fcd9 0008 7fff
000032 ffffff 000c98 ffffcd 000000 fff364 000000 ffffff 000020 0007ff fffff8 01fffc
// clear
0002 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000
000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000
// 40 full-scale samples, saturation at both bounds
0001 0028 7fff 8000 0100 0000 0000 0000 0000 0000 7fff 8000 1000
7fff 8000 0100 0000
7fffff 800000 13ffd8 800000 7fffff ec0000 013fd8 fec000 002800 000000 000000 000000
// clear
0002 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000
000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000
// first sample again from zero
0001 0001 0200 ff00 0180 fe80 0000 0f5c f0a4 0800 1000 0800 f800
0200 ffeb 001e fee0
000200 000100 ffff00 ffffeb fffff5 00000a 00001e 00000f fffff1 fffee0 ffff70 000090
// second sample with start and clear pulsed during the walk
0003 0001 0100 0100 ff00 0080 0000 1000 0400 f000 2000 f000 0c00
0100 0000 ff10 0000
000400 000000 ffffc0 ffffeb fffff5 00000a fffe3e 0000ff ffff3d fffee0 ffff70 000090

/* files.f */
src/fixed_point_pkg.sv
src/backward_ctrl_pkg.sv
src/tanh_backward_block.sv
src/weight_grad_accum.sv
src/backward_ctrl.sv
src/hidden_backward_top.sv
test/tb_hidden_backward.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_hidden_backward
FILELIST = files.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* test/tb_hidden_backward.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_hidden_backward;

  import fixed_point_pkg::*;

  localparam int HID_DIM = 4;
  localparam int IN_DIM  = 3;
  localparam int NUM_W   = HID_DIM * IN_DIM;
  // start to done of one sample
  localparam int RUN_LEN = NUM_W + HID_DIM + 5;

  // record words in order op, repeat count, d, q, x, expected dh, expected weight_grad
  localparam int OFS_D     = 2;
  localparam int OFS_Q     = OFS_D + HID_DIM;
  localparam int OFS_X     = OFS_Q + HID_DIM;
  localparam int OFS_DH    = OFS_X + IN_DIM;
  localparam int OFS_WG    = OFS_DH + HID_DIM;
  localparam int REC_WORDS = OFS_WG + NUM_W;
  localparam int MAX_REC   = 16;

  localparam int OP_SAMPLE = 1;
  localparam int OP_CLEAR  = 2;
  localparam int OP_BUSY   = 3;
  // lands the extra pulses inside the accumulate walk
  localparam int BUSY_DELAY = 10;

  logic                      clk;
  logic                      rst_n;
  logic                      start;
  logic                      clear;
  logic [HID_DIM*GRAD_W-1:0] d;
  logic [HID_DIM*ACT_W-1:0]  q_forward;
  logic [IN_DIM*ACT_W-1:0]   x;
  logic [HID_DIM*GRAD_W-1:0] dh;
  logic [NUM_W*WGRAD_W-1:0]  weight_grad;
  logic                      busy;
  logic                      done;

  logic [31:0] tdata [MAX_REC*REC_WORDS];

  int errors;
  int tests;
  int failed_tests;
  int cycles;
  int cycle_limit;
  int num_rec;

  hidden_backward_top #(
    .HID_DIM (HID_DIM),
    .IN_DIM  (IN_DIM)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .clear       (clear),
    .d           (d),
    .q_forward   (q_forward),
    .x           (x),
    .dh          (dh),
    .weight_grad (weight_grad),
    .busy        (busy),
    .done        (done)
  );

  always #10 clk = ~clk;

  // --------------------------------------------------
  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic string op_name(int op);
    case (op)
      OP_SAMPLE: op_name = "sample";
      OP_CLEAR:  op_name = "clear";
      OP_BUSY:   op_name = "start and clear while busy";
      default:   op_name = "unknown";
    endcase
  endfunction

  task automatic drive_vectors(int base);
    for (int k = 0; k < HID_DIM; k++) begin
      d[k*GRAD_W +: GRAD_W]       = tdata[base + OFS_D + k][GRAD_W-1:0];
      q_forward[k*ACT_W +: ACT_W] = tdata[base + OFS_Q + k][ACT_W-1:0];
    end
    for (int j = 0; j < IN_DIM; j++) begin
      x[j*ACT_W +: ACT_W] = tdata[base + OFS_X + j][ACT_W-1:0];
    end
  endtask

  task automatic check_dh(int base);
    logic [GRAD_W-1:0] exp_v;
    logic [GRAD_W-1:0] act_v;
    for (int k = 0; k < HID_DIM; k++) begin
      exp_v = tdata[base + OFS_DH + k][GRAD_W-1:0];
      act_v = dh[k*GRAD_W +: GRAD_W];
      if (act_v !== exp_v) begin
        $display("[ERROR] %t dh[%0d] expected %h, got %h", $time, k, exp_v, act_v);
        errors++;
      end
    end
  endtask

  task automatic check_wg(int base);
    logic [WGRAD_W-1:0] exp_v;
    logic [WGRAD_W-1:0] act_v;
    for (int k = 0; k < NUM_W; k++) begin
      exp_v = tdata[base + OFS_WG + k][WGRAD_W-1:0];
      act_v = weight_grad[k*WGRAD_W +: WGRAD_W];
      if (act_v !== exp_v) begin
        $display("[ERROR] %t weight_grad[%0d][%0d] expected %h, got %h",
                 $time, k / IN_DIM, k % IN_DIM, exp_v, act_v);
        errors++;
      end
    end
  endtask

  // everything idle and zero
  task automatic check_reset_state;
    if (busy !== 1'b0) begin
      $display("[ERROR] %t busy expected 0, got %b", $time, busy);
      errors++;
    end
    if (done !== 1'b0) begin
      $display("[ERROR] %t done expected 0, got %b", $time, done);
      errors++;
    end
    for (int k = 0; k < HID_DIM; k++) begin
      if (dh[k*GRAD_W +: GRAD_W] !== '0) begin
        $display("[ERROR] %t dh[%0d] expected 0000, got %h", $time, k, dh[k*GRAD_W +: GRAD_W]);
        errors++;
      end
    end
    for (int k = 0; k < NUM_W; k++) begin
      if (weight_grad[k*WGRAD_W +: WGRAD_W] !== '0) begin
        $display("[ERROR] %t weight_grad[%0d][%0d] expected 000000, got %h",
                 $time, k / IN_DIM, k % IN_DIM, weight_grad[k*WGRAD_W +: WGRAD_W]);
        errors++;
      end
    end
  endtask

  task automatic wait_done(output logic seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < RUN_LEN + 10) begin
      @(negedge clk);
      n++;
      if (done) begin
        seen = 1'b1;
      end
    end
  endtask

  task automatic watch_no_done(output logic extra);
    extra = 1'b0;
    repeat (RUN_LEN) begin
      @(negedge clk);
      if (done) begin
        extra = 1'b1;
      end
    end
  endtask

  // one sample, optionally with start and clear pulsed mid-walk
  task automatic run_sample(int base, logic disturb, output logic seen);
    @(negedge clk);
    drive_vectors(base);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (disturb) begin
      repeat (BUSY_DELAY - 1) @(negedge clk);
      if (busy !== 1'b1) begin
        $display("[ERROR] %t busy expected 1, got %b", $time, busy);
        errors++;
      end
      start = 1'b1;
      clear = 1'b1;
      @(negedge clk);
      start = 1'b0;
      clear = 1'b0;
    end
    wait_done(seen);
  endtask

  task automatic report_test(int num, string what, int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %0d (%s): ok", num, what);
    end else begin
      failed_tests++;
      $display("test %0d (%s): %0d errors", num, what, errors - errs_before);
    end
  endtask

  // --------------------------------------------------
  initial begin
    int   base;
    int   op;
    int   reps;
    int   runs;
    int   errs_before;
    logic seen;
    logic extra;
    $timeformat(-9, 0, " ns", 0);
    clk          = 1'b0;
    rst_n        = 1'b0;
    start        = 1'b0;
    clear        = 1'b0;
    d            = '0;
    q_forward    = '0;
    x            = '0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    cycles       = 0;
    for (int i = 0; i < MAX_REC * REC_WORDS; i++) begin
      tdata[i] = '0;
    end
    $readmemh("test/hidden_backward_testdata.hex", tdata);

    // op 0 marks the end of the records
    num_rec = 0;
    runs    = 1;
    while (num_rec < MAX_REC && tdata[num_rec * REC_WORDS] != 0) begin
      runs += int'(tdata[num_rec * REC_WORDS + 1]);
      if (int'(tdata[num_rec * REC_WORDS]) == OP_BUSY) begin
        runs += 1;
      end
      num_rec++;
    end
    cycle_limit = runs * (RUN_LEN + 2) + 50;
    if (num_rec == 0) begin
      $display("no records were read from the test data file");
      errors++;
    end

    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    errs_before = errors;
    check_reset_state();
    report_test(0, "reset state", errs_before);

    for (int r = 0; r < num_rec; r++) begin
      base        = r * REC_WORDS;
      op          = int'(tdata[base]);
      reps        = int'(tdata[base + 1]);
      errs_before = errors;
      if (op == OP_CLEAR) begin
        @(negedge clk);
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        check_wg(base);
      end else if (op == OP_SAMPLE || op == OP_BUSY) begin
        for (int n = 0; n < reps; n++) begin
          run_sample(base, op == OP_BUSY, seen);
          if (!seen) begin
            $display("done never arrived for record %0d, run %0d", r + 1, n + 1);
            errors++;
          end
          check_dh(base);
        end
        check_wg(base);
        if (op == OP_BUSY) begin
          watch_no_done(extra);
          if (extra) begin
            $display("a second done arrived after the start pulsed during busy");
            errors++;
          end
        end
      end else begin
        $display("record %0d has an unknown operation code %0d", r + 1, op);
        errors++;
      end
      report_test(r + 1, op_name(op), errs_before);
    end

    $display("tests run: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/hidden_backward_top.sv */
`timescale 1ns/10ps
`default_nettype none

module hidden_backward_top #(
  parameter int HID_DIM = backward_ctrl_pkg::DEF_HID_DIM,
  parameter int IN_DIM  = backward_ctrl_pkg::DEF_IN_DIM
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                start,
  input  logic                                                clear,
  input  logic [HID_DIM*fixed_point_pkg::GRAD_W-1:0]          d,
  input  logic [HID_DIM*fixed_point_pkg::ACT_W-1:0]           q_forward,
  input  logic [IN_DIM*fixed_point_pkg::ACT_W-1:0]            x,
  output logic [HID_DIM*fixed_point_pkg::GRAD_W-1:0]          dh,
  output logic [HID_DIM*IN_DIM*fixed_point_pkg::WGRAD_W-1:0]  weight_grad,
  output logic                                                busy,
  output logic                                                done
);

  // --------------------------------------------------
  // sequencer handshakes
  logic run;
  logic valid;
  logic accum_start;
  logic accum_clear;
  logic accum_last;

  backward_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .clear       (clear),
    .valid       (valid),
    .accum_last  (accum_last),
    .run         (run),
    .accum_start (accum_start),
    .accum_clear (accum_clear),
    .busy        (busy),
    .done        (done)
  );

  tanh_backward_block #(
    .HID_DIM (HID_DIM)
  ) tanh_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .d         (d),
    .q_forward (q_forward),
    .valid     (valid),
    .dh        (dh)
  );

  // dh goes straight from the tanh bank into the accumulator
  weight_grad_accum #(
    .HID_DIM (HID_DIM),
    .IN_DIM  (IN_DIM)
  ) accum_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .accum_start (accum_start),
    .accum_clear (accum_clear),
    .dh          (dh),
    .x           (x),
    .accum_last  (accum_last),
    .weight_grad (weight_grad)
  );

endmodule

`default_nettype wire

/* src/backward_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module backward_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic clear,
  input  logic valid,
  input  logic accum_last,
  output logic run,
  output logic accum_start,
  output logic accum_clear,
  output logic busy,
  output logic done
);

  import backward_ctrl_pkg::*;

  seq_state_t state;
  seq_state_t state_nxt;

  // --------------------------------------------------
  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_nxt = TANH;
        end
      end
      TANH: begin
        // wait for the last dh of this sample
        if (valid) begin
          state_nxt = ACCUM;
        end
      end
      ACCUM: begin
        if (accum_last) begin
          state_nxt = FINISH;
        end
      end
      FINISH: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // one pulse on the tanh to accumulate handover
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      accum_start <= 1'b0;
    end else begin
      accum_start <= (state == TANH) && valid;
    end
  end

  // --------------------------------------------------
  // run stays high through ACCUM so dh is held
  assign run  = (state == TANH) || (state == ACCUM);
  assign busy = (state != IDLE);
  assign done = (state == FINISH);

  // clear only takes effect between samples
  assign accum_clear = (state == IDLE) && clear;

endmodule

`default_nettype wire

/* src/weight_grad_accum.sv */
`timescale 1ns/10ps
`default_nettype none

module weight_grad_accum #(
  parameter int HID_DIM = backward_ctrl_pkg::DEF_HID_DIM,
  parameter int IN_DIM  = backward_ctrl_pkg::DEF_IN_DIM
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                accum_start,
  input  logic                                                accum_clear,
  input  logic [HID_DIM*fixed_point_pkg::GRAD_W-1:0]          dh,
  input  logic [IN_DIM*fixed_point_pkg::ACT_W-1:0]            x,
  output logic                                                accum_last,
  output logic [HID_DIM*IN_DIM*fixed_point_pkg::WGRAD_W-1:0]  weight_grad
);

  import fixed_point_pkg::*;

  localparam int ROW_W   = (HID_DIM > 1) ? $clog2(HID_DIM) : 1;
  localparam int COL_W   = (IN_DIM > 1) ? $clog2(IN_DIM) : 1;
  localparam int PROD_W  = GRAD_W + ACT_W;
  localparam int PROD_F  = GRAD_F + ACT_F;
  // product is brought back to the gradient scale
  localparam int P_SHIFT = PROD_F - GRAD_F;
  localparam int SUM_W   = PROD_W + 1;

  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(HID_DIM - 1);
  localparam logic [COL_W-1:0] LAST_COL = COL_W'(IN_DIM - 1);

  localparam logic signed [SUM_W-1:0] SUM_MAX = WGRAD_MAX;
  localparam logic signed [SUM_W-1:0] SUM_MIN = WGRAD_MIN;

  // --------------------------------------------------
  grad_t  dh_vec   [HID_DIM];
  act_t   x_vec    [IN_DIM];
  wgrad_t acc_bank [HID_DIM][IN_DIM];

  // outer-product walk
  logic             active;
  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;

  logic signed [PROD_W-1:0] prod_full;
  logic signed [PROD_W-1:0] prod_shift;
  logic signed [SUM_W-1:0]  acc_wide;
  logic signed [SUM_W-1:0]  p_wide;
  logic signed [SUM_W-1:0]  sum_wide;
  wgrad_t                   sum_sat;

  for (genvar i = 0; i < HID_DIM; i++) begin : g_row
    assign dh_vec[i] = dh[i*GRAD_W +: GRAD_W];
    for (genvar j = 0; j < IN_DIM; j++) begin : g_col
      assign weight_grad[(i*IN_DIM+j)*WGRAD_W +: WGRAD_W] = acc_bank[i][j];
    end
  end

  for (genvar j = 0; j < IN_DIM; j++) begin : g_x
    assign x_vec[j] = x[j*ACT_W +: ACT_W];
  end

  // one shifted product and a saturating add per cycle
  always_comb begin
    prod_full  = dh_vec[row] * x_vec[col];
    prod_shift = prod_full >>> P_SHIFT;
    acc_wide   = acc_bank[row][col];
    p_wide     = prod_shift;
    sum_wide   = acc_wide + p_wide;
    if (sum_wide > SUM_MAX) begin
      sum_sat = WGRAD_MAX;
    end else if (sum_wide < SUM_MIN) begin
      sum_sat = WGRAD_MIN;
    end else begin
      sum_sat = wgrad_t'(sum_wide);
    end
  end

  assign accum_last = active && (row == LAST_ROW) && (col == LAST_COL);

  // --------------------------------------------------
  // row-major walk, row = hidden unit, col = input
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      row    <= '0;
      col    <= '0;
    end else if (accum_start) begin
      active <= 1'b1;
      row    <= '0;
      col    <= '0;
    end else if (active) begin
      if (col == LAST_COL) begin
        col <= '0;
        if (row == LAST_ROW) begin
          active <= 1'b0;
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // clear wins over a write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < HID_DIM; r++) begin
        for (int c = 0; c < IN_DIM; c++) begin
          acc_bank[r][c] <= '0;
        end
      end
    end else if (accum_clear) begin
      for (int r = 0; r < HID_DIM; r++) begin
        for (int c = 0; c < IN_DIM; c++) begin
          acc_bank[r][c] <= '0;
        end
      end
    end else if (active) begin
      acc_bank[row][col] <= sum_sat;
    end
  end

endmodule

`default_nettype wire

/* src/tanh_backward_block.sv */
`timescale 1ns/10ps
`default_nettype none

module tanh_backward_block #(
  parameter int HID_DIM = backward_ctrl_pkg::DEF_HID_DIM
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       run,
  input  logic [HID_DIM*fixed_point_pkg::GRAD_W-1:0] d,
  input  logic [HID_DIM*fixed_point_pkg::ACT_W-1:0]  q_forward,
  output logic                                       valid,
  output logic [HID_DIM*fixed_point_pkg::GRAD_W-1:0] dh
);

  import fixed_point_pkg::*;

  localparam int IDX_W = (HID_DIM > 1) ? $clog2(HID_DIM) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(HID_DIM - 1);

  // --------------------------------------------------
  // unpacked views of the flat vectors
  grad_t d_vec   [HID_DIM];
  act_t  q_vec   [HID_DIM];
  grad_t dh_bank [HID_DIM];

  // issue counter
  logic [IDX_W-1:0] cnt;
  logic             issued;

  // index delay line, one entry per stage
  logic [IDX_W-1:0] idx_s1;
  logic [IDX_W-1:0] idx_s2;
  logic             v_s1;
  logic             v_s2;

  // stage data
  act_t sq_s1;
  act_t one_minus_s2;
  logic all_written;

  // full-width products
  logic signed [2*ACT_W-1:0]        q_sq_full;
  logic signed [GRAD_W+ACT_W-1:0]   d_s_full;

  for (genvar i = 0; i < HID_DIM; i++) begin : g_unpack
    assign d_vec[i] = d[i*GRAD_W +: GRAD_W];
    assign q_vec[i] = q_forward[i*ACT_W +: ACT_W];
    assign dh[i*GRAD_W +: GRAD_W] = dh_bank[i];
  end

  always_comb begin
    q_sq_full = q_vec[cnt] * q_vec[cnt];
    // d is Q.8, 1 - q^2 is Q.12, so drop ACT_F bits to get back to Q.8
    d_s_full  = d_vec[idx_s2] * one_minus_s2;
  end

  assign valid = run & all_written;

  // --------------------------------------------------
  // counter and stage valid bits, all cleared when run drops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt         <= '0;
      issued      <= 1'b0;
      v_s1        <= 1'b0;
      v_s2        <= 1'b0;
      all_written <= 1'b0;
    end else if (!run) begin
      cnt         <= '0;
      issued      <= 1'b0;
      v_s1        <= 1'b0;
      v_s2        <= 1'b0;
      all_written <= 1'b0;
    end else begin
      v_s1 <= !issued;
      v_s2 <= v_s1;
      if (!issued) begin
        if (cnt == LAST_IDX) begin
          issued <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
      if (v_s2 && (idx_s2 == LAST_IDX)) begin
        all_written <= 1'b1;
      end
    end
  end

  // stage one squares q, stage two forms 1 - q^2
  always_ff @(posedge clk) begin
    sq_s1        <= act_t'(q_sq_full >>> ACT_F);
    idx_s1       <= cnt;
    one_minus_s2 <= ACT_ONE - sq_s1;
    idx_s2       <= idx_s1;
  end

  // write stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < HID_DIM; k++) begin
        dh_bank[k] <= '0;
      end
    end else if (run && v_s2) begin
      dh_bank[idx_s2] <= grad_t'(d_s_full >>> ACT_F);
    end
  end

endmodule

`default_nettype wire

/* src/backward_ctrl_pkg.sv */
`default_nettype none

package backward_ctrl_pkg;

  // --------------------------------------------------
  // per-sample sequencer states
  typedef enum logic [1:0] {
    IDLE,
    TANH,
    ACCUM,
    FINISH
  } seq_state_t;

  // --------------------------------------------------
  // default layer dimensions, overridden from the top level
  localparam int DEF_HID_DIM = 4;
  localparam int DEF_IN_DIM  = 3;

endpackage

`default_nettype wire

/* src/fixed_point_pkg.sv */
`default_nettype none

package fixed_point_pkg;

  // --------------------------------------------------
  // activation format, used for tanh outputs and layer inputs
  localparam int ACT_W = 16;
  localparam int ACT_F = 12;

  // gradient format, upstream d and local dh
  localparam int GRAD_W = 16;
  localparam int GRAD_F = 8;

  // weight-gradient accumulators keep the gradient fraction
  // and add integer headroom for a whole batch
  localparam int WGRAD_W = 24;

  // --------------------------------------------------
  typedef logic signed [ACT_W-1:0]   act_t;
  typedef logic signed [GRAD_W-1:0]  grad_t;
  typedef logic signed [WGRAD_W-1:0] wgrad_t;

  // 1.0 in activation format
  localparam act_t ACT_ONE = act_t'(1 << ACT_F);

  // saturation bounds of the accumulators
  localparam wgrad_t WGRAD_MAX = {1'b0, {(WGRAD_W-1){1'b1}}};
  localparam wgrad_t WGRAD_MIN = {1'b1, {(WGRAD_W-1){1'b0}}};

endpackage

`default_nettype wire
